// ==== sig_gen_pkg.sv ====
package sig_gen_pkg;

   localparam int PHASE_W  = 32;  // phase accumulator
   localparam int SAMPLE_W = 12;  // signed output samples

   typedef logic [PHASE_W-1:0]         phase_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // raw channel shapes
   typedef enum logic [1:0] {
      WAVE_SAW,
      WAVE_SQUARE,
      WAVE_TRIANGLE,
      WAVE_RAMP_DOWN
   } wave_kind_e;

   // modulated channel schemes, all on a triangle carrier
   typedef enum logic [1:0] {
      MOD_ASK,
      MOD_FSK,
      MOD_BPSK,
      MOD_CARRIER
   } mod_kind_e;

   typedef struct packed {
      logic       modulated;
      wave_kind_e kind;
   } wave_view_s;

   typedef struct packed {
      logic      modulated;
      mod_kind_e kind;
   } mod_view_s;

   // one mode word, kind field read by the flag
   typedef union packed {
      wave_view_s wave;
      mod_view_s  modu;
   } dds_mode_u;

   localparam logic [4:0] LFSR_SEED = 5'b00001;

endpackage

// ==== key_codes_pkg.sv ====
package key_codes_pkg;

   localparam int HELD_W = 8;  // digit keys 1 to 8

   // ps/2 set 2 make codes
   localparam logic [7:0] SC_MAKE_1 = 8'h16;
   localparam logic [7:0] SC_MAKE_2 = 8'h1E;
   localparam logic [7:0] SC_MAKE_3 = 8'h26;
   localparam logic [7:0] SC_MAKE_4 = 8'h25;
   localparam logic [7:0] SC_MAKE_5 = 8'h2E;
   localparam logic [7:0] SC_MAKE_6 = 8'h36;
   localparam logic [7:0] SC_MAKE_7 = 8'h3D;
   localparam logic [7:0] SC_MAKE_8 = 8'h3E;

   // decoder reports a release as make + 80h
   localparam logic [7:0] SC_BREAK_1 = SC_MAKE_1 + 8'h80;
   localparam logic [7:0] SC_BREAK_2 = SC_MAKE_2 + 8'h80;
   localparam logic [7:0] SC_BREAK_3 = SC_MAKE_3 + 8'h80;
   localparam logic [7:0] SC_BREAK_4 = SC_MAKE_4 + 8'h80;
   localparam logic [7:0] SC_BREAK_5 = SC_MAKE_5 + 8'h80;
   localparam logic [7:0] SC_BREAK_6 = SC_MAKE_6 + 8'h80;
   localparam logic [7:0] SC_BREAK_7 = SC_MAKE_7 + 8'h80;
   localparam logic [7:0] SC_BREAK_8 = SC_MAKE_8 + 8'h80;

   // position of each key in held_keys
   localparam int KEY_1_BIT = 0;
   localparam int KEY_2_BIT = 1;
   localparam int KEY_3_BIT = 2;
   localparam int KEY_4_BIT = 3;
   localparam int KEY_5_BIT = 4;
   localparam int KEY_6_BIT = 5;
   localparam int KEY_7_BIT = 6;
   localparam int KEY_8_BIT = 7;

endpackage

// ==== key_state_if.sv ====
`timescale 1ns/1ps

interface key_state_if
   import sig_gen_pkg::*;
   import key_codes_pkg::*;
();

   logic [HELD_W-1:0] held_keys;    // one bit per digit key
   dds_mode_u         mod_mode;
   dds_mode_u         raw_mode;
   logic              sel_changed;  // one cycle after a digit make

   modport writer (output held_keys, output mod_mode, output raw_mode, output sel_changed);

   modport ctrl (input sel_changed);

   modport reader (input held_keys, input mod_mode, input raw_mode);

endinterface

// ==== keyboard_state.sv ====
`timescale 1ns/1ps

module keyboard_state
   import sig_gen_pkg::*;
   import key_codes_pkg::*;
(
   input  logic        CLK_25MHZ,
   input  logic        reset_from_key,
   input  logic        key_valid,
   input  logic [7:0]  key_code,
   key_state_if.writer ks
);

   logic [HELD_W-1:0] make_hot;   // one-hot, this cycle only
   logic [HELD_W-1:0] break_hot;

   always_comb
   begin
      make_hot  = '0;
      break_hot = '0;
      if (key_valid)
      begin
         case (key_code)
            SC_MAKE_1:  make_hot[KEY_1_BIT]  = 1'b1;
            SC_MAKE_2:  make_hot[KEY_2_BIT]  = 1'b1;
            SC_MAKE_3:  make_hot[KEY_3_BIT]  = 1'b1;
            SC_MAKE_4:  make_hot[KEY_4_BIT]  = 1'b1;
            SC_MAKE_5:  make_hot[KEY_5_BIT]  = 1'b1;
            SC_MAKE_6:  make_hot[KEY_6_BIT]  = 1'b1;
            SC_MAKE_7:  make_hot[KEY_7_BIT]  = 1'b1;
            SC_MAKE_8:  make_hot[KEY_8_BIT]  = 1'b1;
            SC_BREAK_1: break_hot[KEY_1_BIT] = 1'b1;
            SC_BREAK_2: break_hot[KEY_2_BIT] = 1'b1;
            SC_BREAK_3: break_hot[KEY_3_BIT] = 1'b1;
            SC_BREAK_4: break_hot[KEY_4_BIT] = 1'b1;
            SC_BREAK_5: break_hot[KEY_5_BIT] = 1'b1;
            SC_BREAK_6: break_hot[KEY_6_BIT] = 1'b1;
            SC_BREAK_7: break_hot[KEY_7_BIT] = 1'b1;
            SC_BREAK_8: break_hot[KEY_8_BIT] = 1'b1;
            default:    ;  // other keys ignored
         endcase
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         ks.held_keys     <= '0;
         ks.raw_mode.wave <= '{modulated: 1'b0, kind: WAVE_SAW};
         ks.mod_mode.modu <= '{modulated: 1'b1, kind: MOD_ASK};
         ks.sel_changed   <= 1'b0;
      end
      else
      begin
         ks.held_keys   <= (ks.held_keys | make_hot) & ~break_hot;
         ks.sel_changed <= |make_hot;   // repeat makes restart too

         // keys 1..4 pick the raw shape
         if (make_hot[KEY_1_BIT])
            ks.raw_mode.wave.kind <= WAVE_SAW;
         if (make_hot[KEY_2_BIT])
            ks.raw_mode.wave.kind <= WAVE_SQUARE;
         if (make_hot[KEY_3_BIT])
            ks.raw_mode.wave.kind <= WAVE_TRIANGLE;
         if (make_hot[KEY_4_BIT])
            ks.raw_mode.wave.kind <= WAVE_RAMP_DOWN;

         // keys 5..8 pick the modulation
         if (make_hot[KEY_5_BIT])
            ks.mod_mode.modu.kind <= MOD_ASK;
         if (make_hot[KEY_6_BIT])
            ks.mod_mode.modu.kind <= MOD_FSK;
         if (make_hot[KEY_7_BIT])
            ks.mod_mode.modu.kind <= MOD_BPSK;
         if (make_hot[KEY_8_BIT])
            ks.mod_mode.modu.kind <= MOD_CARRIER;
      end
   end

endmodule

// ==== lfsr5.sv ====
`timescale 1ns/1ps

module lfsr5
   import sig_gen_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  logic       step,
   output logic [4:0] value
);

   logic feedback;

   // x^5 + x^3 + 1, 31 states, never all zero
   assign feedback = value[4] ^ value[2];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         value <= LFSR_SEED;
      else if (step)
         value <= {value[3:0], feedback};
   end

endmodule

// ==== dds_channel.sv ====
`timescale 1ns/1ps

module dds_channel
   import sig_gen_pkg::*;
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  logic      restart,
   input  dds_mode_u mode,
   input  logic      data_bit,
   input  phase_t    base_inc,
   input  phase_t    fsk_inc,
   output sample_t   sample
);

   localparam sample_t FULL_POS = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
   localparam sample_t FULL_NEG = -FULL_POS;

   phase_t              acc;
   phase_t              inc;
   logic [SAMPLE_W-1:0] top_bits;
   logic [SAMPLE_W-2:0] fold;
   sample_t             saw;
   sample_t             square;
   sample_t             tri_wave;
   sample_t             shaped;

   ////////////////////////////////////////////////////////////
   // phase accumulator

   // fsk switches the step on the data bit
   assign inc = (mode.modu.modulated && mode.modu.kind == MOD_FSK && data_bit)
                ? fsk_inc : base_inc;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || restart)
         acc <= '0;
      else
         acc <= acc + inc;
   end

   ////////////////////////////////////////////////////////////
   // waveform shaping from the top phase bits

   assign top_bits = acc[PHASE_W-1 -: SAMPLE_W];
   assign saw      = sample_t'({~top_bits[SAMPLE_W-1], top_bits[SAMPLE_W-2:0]});
   assign square   = top_bits[SAMPLE_W-1] ? FULL_NEG : FULL_POS;

   // fold the second half back down, then x2 and recenter
   assign fold     = top_bits[SAMPLE_W-1] ? ~top_bits[SAMPLE_W-2:0] : top_bits[SAMPLE_W-2:0];
   assign tri_wave = sample_t'({~fold[SAMPLE_W-2], fold[SAMPLE_W-3:0], 1'b0});

   always_comb
   begin
      shaped = tri_wave;
      if (!mode.wave.modulated)
      begin
         case (mode.wave.kind)
            WAVE_SAW:       shaped = saw;
            WAVE_SQUARE:    shaped = square;
            WAVE_TRIANGLE:  shaped = tri_wave;
            WAVE_RAMP_DOWN: shaped = -saw;
            default:        shaped = saw;
         endcase
      end
      else
      begin
         case (mode.modu.kind)
            MOD_ASK:  shaped = data_bit ? tri_wave : '0;         // on/off keying
            MOD_BPSK: shaped = data_bit ? tri_wave : -tri_wave;  // 180 deg flip
            default:  shaped = tri_wave;   // fsk and bare carrier
         endcase
      end
   end

   // one cycle behind the phase
   always_ff @(posedge CLK_25MHZ)
   begin
      sample <= shaped;
   end

endmodule

// ==== sig_gen_ctrl.sv ====
`timescale 1ns/1ps

module sig_gen_ctrl
   import sig_gen_pkg::*;
#(
   parameter int LFSR_DIV   = 25_000_000,
   parameter int SAMPLE_DIV = 70_000
)
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   key_state_if.ctrl  ks,
   output logic       lfsr_step,
   output logic       restart,
   input  logic [4:0] lfsr_in,
   input  sample_t    mod_in,
   input  sample_t    raw_in,
   output logic       out_req,
   input  logic       out_ack,
   output sample_t    mod_sample,
   output sample_t    raw_sample,
   output logic [4:0] lfsr_value
);

   localparam int LFSR_CW   = $clog2(LFSR_DIV);
   localparam int SAMPLE_CW = $clog2(SAMPLE_DIV);

   typedef enum logic [1:0] {
      HS_IDLE,
      HS_WAIT_ACK_HI,
      HS_WAIT_ACK_LO
   } hs_state_e;

   logic [LFSR_CW-1:0]   lfsr_cnt;
   logic [SAMPLE_CW-1:0] sample_cnt;
   logic                 strobe;
   logic                 capture;
   hs_state_e            state;

   ////////////////////////////////////////////////////////////
   // tick dividers

   assign lfsr_step = (lfsr_cnt == LFSR_CW'(LFSR_DIV - 1));
   assign strobe    = (sample_cnt == SAMPLE_CW'(SAMPLE_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_cnt   <= '0;
         sample_cnt <= '0;
      end
      else
      begin
         lfsr_cnt   <= lfsr_step ? '0 : lfsr_cnt + 1'b1;
         sample_cnt <= strobe ? '0 : sample_cnt + 1'b1;
      end
   end

   // both channels realign on a new mode
   assign restart = ks.sel_changed;

   ////////////////////////////////////////////////////////////
   // four-phase output handshake

   assign out_req = (state == HS_WAIT_ACK_HI);
   assign capture = strobe && !out_req && !out_ack;   // busy strobes are dropped

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         state <= HS_IDLE;
      else
      begin
         case (state)
            HS_IDLE:
               if (capture)
                  state <= HS_WAIT_ACK_HI;
            HS_WAIT_ACK_HI:
               if (out_ack)
                  state <= HS_WAIT_ACK_LO;
            HS_WAIT_ACK_LO:
               if (capture)
                  state <= HS_WAIT_ACK_HI;   // ack just fell on a strobe
               else if (!out_ack)
                  state <= HS_IDLE;
            default:
               state <= HS_IDLE;
         endcase
      end
   end

   // held from req rise until ack falls
   always_ff @(posedge CLK_25MHZ)
   begin
      if (capture)
      begin
         mod_sample <= mod_in;
         raw_sample <= raw_in;
         lfsr_value <= lfsr_in;
      end
   end

endmodule

// ==== sig_gen_top.sv ====
`timescale 1ns/1ps

module sig_gen_top
   import sig_gen_pkg::*;
   import key_codes_pkg::*;
#(
   parameter int LFSR_DIV   = 25_000_000,  // one lfsr step per second
   parameter int SAMPLE_DIV = 70_000
)
(
   input  logic              CLK_25MHZ,
   input  logic              reset_from_key,
   input  logic              key_valid,
   input  logic [7:0]        key_code,
   input  phase_t            base_inc,
   input  phase_t            fsk_inc,
   output logic              out_req,
   input  logic              out_ack,
   output sample_t           mod_sample,
   output sample_t           raw_sample,
   output logic [4:0]        lfsr_value,
   output logic [HELD_W-1:0] held_keys
);

   logic [4:0] lfsr;
   logic       lfsr_step;
   logic       restart;
   sample_t    mod_wave;
   sample_t    raw_wave;

   key_state_if ks ();

   keyboard_state keyboard_state_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_valid      (key_valid),
      .key_code       (key_code),
      .ks             (ks)
   );

   lfsr5 lfsr5_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .step           (lfsr_step),
      .value          (lfsr)
   );

   ////////////////////////////////////////////////////////////
   // two channels, same phase restart and data bit

   dds_channel mod_chan (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .restart        (restart),
      .mode           (ks.mod_mode),
      .data_bit       (lfsr[0]),
      .base_inc       (base_inc),
      .fsk_inc        (fsk_inc),
      .sample         (mod_wave)
   );

   dds_channel raw_chan (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .restart        (restart),
      .mode           (ks.raw_mode),
      .data_bit       (lfsr[0]),     // ignored with flag clear
      .base_inc       (base_inc),
      .fsk_inc        (fsk_inc),
      .sample         (raw_wave)
   );

   sig_gen_ctrl #(
      .LFSR_DIV   (LFSR_DIV),
      .SAMPLE_DIV (SAMPLE_DIV)
   ) sig_gen_ctrl_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .ks             (ks),
      .lfsr_step      (lfsr_step),
      .restart        (restart),
      .lfsr_in        (lfsr),
      .mod_in         (mod_wave),
      .raw_in         (raw_wave),
      .out_req        (out_req),
      .out_ack        (out_ack),
      .mod_sample     (mod_sample),
      .raw_sample     (raw_sample),
      .lfsr_value     (lfsr_value)
   );

   assign held_keys = ks.held_keys;

endmodule

// ==== sig_gen_checker.sv ====
`timescale 1ns/1ps

module sig_gen_checker
   import sig_gen_pkg::*;
   import key_codes_pkg::*;
#(
   parameter int LFSR_DIV   = 40,
   parameter int SAMPLE_DIV = 12
)
(
   input logic              CLK_25MHZ,
   input logic              reset_from_key,
   input logic              key_valid,
   input logic [7:0]        key_code,
   input phase_t            base_inc,
   input phase_t            fsk_inc,
   input logic              out_req,
   input logic              out_ack,
   input sample_t           mod_sample,
   input sample_t           raw_sample,
   input logic [4:0]        lfsr_value,
   input logic [HELD_W-1:0] held_keys
);

   localparam logic [7:0] MAKE_CODES [HELD_W] = '{SC_MAKE_1, SC_MAKE_2, SC_MAKE_3,
      SC_MAKE_4, SC_MAKE_5, SC_MAKE_6, SC_MAKE_7, SC_MAKE_8};

   int error_count   = 0;
   int check_count   = 0;
   int capture_count = 0;

   logic [HELD_W-1:0] m_held;
   logic [1:0]        m_raw_kind;
   logic [1:0]        m_mod_kind;
   logic              m_sel;
   logic              m_req;
   logic              prev_req;
   logic              strobe;
   logic              capture;
   phase_t            m_acc_mod;
   phase_t            m_acc_raw;
   phase_t            inc_mod;
   sample_t           m_smp_mod;
   sample_t           m_smp_raw;
   sample_t           m_cap_mod;
   sample_t           m_cap_raw;
   logic [4:0]        m_lfsr;
   logic [4:0]        m_cap_lfsr;
   int                m_lfsr_cnt;
   int                m_smp_cnt;

   // reference shapes, all arithmetic on the top 12 phase bits
   function automatic sample_t shape(phase_t acc, logic modulated, logic [1:0] kind,
                                     logic data);
      int top;
      int saw;
      int fold;
      int tri_v;
      int val;
      top   = int'(acc[31:20]);
      saw   = top - 2048;
      fold  = (top >= 2048) ? 4095 - top : top;
      tri_v = fold * 2 - 2048;
      if (!modulated)
         case (kind)
            2'd0:    val = saw;
            2'd1:    val = (top >= 2048) ? -2047 : 2047;
            2'd2:    val = tri_v;
            default: val = -saw;
         endcase
      else if (kind == 2'd0)
         val = data ? tri_v : 0;     // ask
      else if (kind == 2'd2)
         val = data ? tri_v : -tri_v;
      else
         val = tri_v;
      return sample_t'(val);
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      check_count++;
      if (expected !== actual)
      begin
         error_count++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_held     = '0;
         m_raw_kind = 2'd0;
         m_mod_kind = 2'd0;
         m_sel      = 1'b0;
         m_req      = 1'b0;
         prev_req   = 1'b0;
         m_acc_mod  = '0;
         m_acc_raw  = '0;
         m_lfsr     = LFSR_SEED;
         m_lfsr_cnt = 0;
         m_smp_cnt  = 0;
         m_smp_mod  = shape('0, 1'b1, 2'd0, LFSR_SEED[0]);
         m_smp_raw  = shape('0, 1'b0, 2'd0, 1'b0);
      end
      else
      begin
         ////////////////////////////////////////////////////////////
         // compare what the DUT shows before this edge
         compare("held_keys", 32'(m_held), 32'(held_keys));
         compare("out_req", 32'(m_req), 32'(out_req));
         if (out_req && !prev_req)
            capture_count++;
         if (out_req || out_ack)   // data held through the whole handshake
         begin
            compare("mod_sample", 32'(m_cap_mod), 32'(mod_sample));
            compare("raw_sample", 32'(m_cap_raw), 32'(raw_sample));
            compare("lfsr_value", 32'(m_cap_lfsr), 32'(lfsr_value));
         end
         prev_req = out_req;

         ////////////////////////////////////////////////////////////
         // advance the model one cycle
         strobe  = (m_smp_cnt == SAMPLE_DIV - 1);
         capture = strobe && !m_req && !out_ack;
         if (capture)
         begin
            m_cap_mod  = m_smp_mod;
            m_cap_raw  = m_smp_raw;
            m_cap_lfsr = m_lfsr;
            m_req      = 1'b1;
         end
         else if (m_req && out_ack)
            m_req = 1'b0;

         inc_mod   = (m_mod_kind == 2'd1 && m_lfsr[0]) ? fsk_inc : base_inc;
         m_smp_mod = shape(m_acc_mod, 1'b1, m_mod_kind, m_lfsr[0]);
         m_smp_raw = shape(m_acc_raw, 1'b0, m_raw_kind, 1'b0);
         m_acc_mod = m_sel ? '0 : m_acc_mod + inc_mod;
         m_acc_raw = m_sel ? '0 : m_acc_raw + base_inc;

         if (m_lfsr_cnt == LFSR_DIV - 1)
            m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         m_lfsr_cnt = (m_lfsr_cnt == LFSR_DIV - 1) ? 0 : m_lfsr_cnt + 1;
         m_smp_cnt  = strobe ? 0 : m_smp_cnt + 1;

         m_sel = 1'b0;
         if (key_valid)
            for (int i = 0; i < HELD_W; i++)
            begin
               if (key_code == MAKE_CODES[i])
               begin
                  m_held[i] = 1'b1;
                  m_sel     = 1'b1;
                  if (i < 4)
                     m_raw_kind = 2'(i);
                  else
                     m_mod_kind = 2'(i - 4);
               end
               if (key_code == MAKE_CODES[i] + 8'h80)
                  m_held[i] = 1'b0;   // break of an idle key is harmless
            end
      end
   end

endmodule

// ==== tb_sig_gen.sv ====
`timescale 1ns/1ps

module tb_sig_gen;
   import sig_gen_pkg::*;
   import key_codes_pkg::*;

   logic              CLK_25MHZ;
   logic              reset_from_key;
   logic              key_valid;
   logic [7:0]        key_code;
   phase_t            base_inc;
   phase_t            fsk_inc;
   logic              out_req;
   logic              out_ack;
   sample_t           mod_sample;
   sample_t           raw_sample;
   logic [4:0]        lfsr_value;
   logic [HELD_W-1:0] held_keys;

   logic [31:0] seed = 32'h802f;
   int          tb_errors  = 0;
   int          handshakes = 0;
   int          min_delay  = 0;
   int          max_delay  = 20;

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz
   end

   sig_gen_top #(.LFSR_DIV(40), .SAMPLE_DIV(12)) sig_gen_top_inst (.*);

   sig_gen_checker #(.LFSR_DIV(40), .SAMPLE_DIV(12)) checker_inst (.*);

   function logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [7:0] make_of(int k);
      case (k)
         1:       return SC_MAKE_1;
         2:       return SC_MAKE_2;
         3:       return SC_MAKE_3;
         4:       return SC_MAKE_4;
         5:       return SC_MAKE_5;
         6:       return SC_MAKE_6;
         7:       return SC_MAKE_7;
         default: return SC_MAKE_8;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $finish;
   endtask

   task automatic key_event(input logic [7:0] code);
      @(posedge CLK_25MHZ);
      key_valid <= 1'b1;
      key_code  <= code;
      @(posedge CLK_25MHZ);
      key_valid <= 1'b0;
   endtask

   task automatic wait_handshakes(input int n);
      int target;
      int t;
      target = handshakes + n;
      t      = 0;
      while (handshakes < target)
      begin
         @(posedge CLK_25MHZ);
         t++;
         if (t > n * 300)
            abort_run("timeout, handshakes stopped completing");
      end
   endtask

   task automatic report(input string name);
      $display("test %s done, checks %0d, errors %0d", name,
               checker_inst.check_count, checker_inst.error_count + tb_errors);
   endtask

   ////////////////////////////////////////////////////////////
   // handshake receiver with random ack delays
   initial
   begin
      int t;
      int delay;
      t = 0;
      while (reset_from_key !== 1'b0)
      begin
         @(posedge CLK_25MHZ);
         t++;
         if (t > 100)
            abort_run("timeout, reset never released");
      end
      forever
      begin
         t = 0;
         while (!out_req)
         begin
            @(posedge CLK_25MHZ);
            t++;
            if (t > 500)
               abort_run("timeout, out_req never rose");
         end
         delay = min_delay + int'(lcg_next() >> 16) % (max_delay - min_delay + 1);
         repeat (delay) @(posedge CLK_25MHZ);
         out_ack <= 1'b1;
         t = 0;
         while (out_req)
         begin
            @(posedge CLK_25MHZ);
            t++;
            if (t > 500)
               abort_run("timeout, out_req stuck high after ack");
         end
         delay = min_delay + int'(lcg_next() >> 16) % (max_delay - min_delay + 1);
         repeat (delay) @(posedge CLK_25MHZ);
         out_ack <= 1'b0;
         handshakes++;
      end
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   initial
   begin
      int          k;
      logic [31:0] r;
      reset_from_key = 1'b1;
      key_valid      = 1'b0;
      key_code       = 8'h00;
      base_inc       = '0;
      fsk_inc        = '0;
      out_ack        = 1'b0;
      repeat (16) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      @(posedge CLK_25MHZ);
      if (out_req !== 1'b0 || held_keys !== '0)
      begin
         tb_errors++;
         $display("out_req or held_keys not clear after reset");
      end
      wait_handshakes(1);   // first capture carries the seed
      report("reset");

      repeat (60)
      begin
         k = 1 + int'(lcg_next() >> 16) % 8;
         r = lcg_next();
         key_event(r[20] ? make_of(k) + 8'h80 : make_of(k));
         repeat (int'(lcg_next() >> 16) % 3) @(posedge CLK_25MHZ);
      end
      report("held keys");

      for (int w = 1; w <= 4; w++)
      begin
         base_inc <= lcg_next() >> 6;
         key_event(make_of(w));
         wait_handshakes(6);
      end
      report("raw waveforms");

      for (int m = 5; m <= 8; m++)
      begin
         base_inc <= lcg_next() >> 6;
         fsk_inc  <= lcg_next() >> 5;
         key_event(make_of(m));
         wait_handshakes(8);
      end
      report("modulations");

      wait_handshakes(40);   // many lfsr steps between captures
      report("lfsr sequence");

      min_delay = 15;
      max_delay = 60;
      wait_handshakes(15);
      report("back-pressure");

      $display("checks %0d, errors %0d, captures %0d", checker_inst.check_count,
               checker_inst.error_count + tb_errors, checker_inst.capture_count);
      if (checker_inst.error_count + tb_errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== sig_gen_top.f ====
sig_gen_pkg.sv
key_codes_pkg.sv
key_state_if.sv
keyboard_state.sv
lfsr5.sv
dds_channel.sv
sig_gen_ctrl.sv
sig_gen_top.sv
sig_gen_checker.sv
tb_sig_gen.sv

// ==== Makefile ====
SRCS := $(shell cat sig_gen_top.f)

obj_dir/Vtb_sig_gen: $(SRCS) sig_gen_top.f
	verilator --binary -Wno-fatal --top-module tb_sig_gen -f sig_gen_top.f

.PHONY: run clean

run: obj_dir/Vtb_sig_gen
	./obj_dir/Vtb_sig_gen | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
